/* logic/uc_pkg.sv */
// Uncached handler package: widths, opcode, state and memory enums, bus structs and op helpers
package uc_pkg;

    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 64;
    localparam int BE_W          = 8;
    localparam int TAG_W         = 8;
    localparam int SIZE_W        = 3;
    localparam int LINE_OFFSET_W = 5;
    // Byte offset inside one 8-byte word
    localparam int WORD_OFF_W    = 3;

    localparam logic SC_SUCCESS = 1'b0;
    localparam logic SC_FAILURE = 1'b1;

    typedef enum logic [3:0] {
        OP_LOAD, OP_STORE, OP_LR, OP_SC, OP_SWAP, OP_ADD, OP_AND,
        OP_OR, OP_XOR, OP_MAX, OP_MAXU, OP_MIN, OP_MINU
    } uc_op_e;

    typedef enum logic [2:0] {
        UC_IDLE, UC_MEM_REQ, UC_MEM_W_REQ, UC_MEM_WDATA_REQ, UC_MEM_WAIT_RSP, UC_CORE_RSP
    } uc_state_e;

    typedef enum logic [1:0] {
        MEM_READ, MEM_WRITE, MEM_ATOMIC
    } mem_cmd_e;

    typedef enum logic [3:0] {
        AMO_LDEX, AMO_STEX, AMO_SWAP, AMO_ADD, AMO_CLR, AMO_SET,
        AMO_EOR, AMO_SMAX, AMO_UMAX, AMO_SMIN, AMO_UMIN
    } mem_amo_e;

    typedef struct packed {
        uc_op_e              op;
        logic [ADDR_W-1:0]   addr;
        logic [SIZE_W-1:0]   size;
        logic [DATA_W-1:0]   data;
        logic [BE_W-1:0]     be;
        logic [TAG_W-1:0]    tag;
        logic                need_rsp;
    } uc_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [SIZE_W-1:0]   size;
        mem_cmd_e            cmd;
        mem_amo_e            amo;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [BE_W-1:0]     be;
    } mem_wdata_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic                error;
    } mem_rresp_t;

    typedef struct packed {
        logic                error;
        logic                is_atomic;
    } mem_wresp_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic [TAG_W-1:0]    tag;
        logic                error;
    } core_rsp_t;

    // Read-modify-write AMOs, LR and SC excluded
    function automatic logic is_amo_op(input uc_op_e op);
        return op inside {OP_SWAP, OP_ADD, OP_AND, OP_OR, OP_XOR,
                          OP_MAX, OP_MAXU, OP_MIN, OP_MINU};
    endfunction

    function automatic logic is_atomic_op(input uc_op_e op);
        return (op inside {OP_LR, OP_SC}) || is_amo_op(op);
    endfunction

endpackage

/* logic/uc_ctrl.sv */
// Uncached request FSM, memory handshake control and reservation strobes
`timescale 1ns/1ps

module uc_ctrl import uc_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    req_valid_i,
    input  uc_op_e  req_op_i,
    input  uc_req_t req_q_i,
    input  logic    rsrv_hit_i,
    input  logic    mem_rd_ready_i,
    input  logic    mem_wr_ready_i,
    input  logic    mem_wdata_ready_i,
    input  logic    mem_rresp_valid_i,
    input  logic    mem_wresp_valid_i,
    input  logic    core_rsp_ready_i,
    output logic    req_ready_o,
    output logic    capture_o,
    output logic    mem_rd_valid_o,
    output logic    mem_wr_valid_o,
    output logic    mem_wdata_valid_o,
    output logic    rsrv_set_o,
    output logic    rsrv_clr_o,
    output logic    lr_done_o,
    output logic    rsp_capture_o,
    output logic    sc_nores_o,
    output logic    core_rsp_valid_o
);

    uc_state_e state_q, state_d;
    logic      rd_seen_q, rd_seen_d;
    logic      wr_seen_q, wr_seen_d;
    logic      accept;
    logic      op_rd;
    logic      rd_done, wr_done, mem_done;

    assign accept = req_valid_i & req_ready_o;

    // Loads and LR go out on the read channel, all else on the write channels
    assign op_rd   = (req_q_i.op == OP_LOAD) || (req_q_i.op == OP_LR);
    assign rd_done = rd_seen_q | mem_rresp_valid_i;
    assign wr_done = wr_seen_q | mem_wresp_valid_i;

    always_comb begin
        if (is_amo_op(req_q_i.op)) begin
            // AMO needs both the old data and the write ack
            mem_done = rd_done & wr_done;
        end else if (op_rd) begin
            mem_done = mem_rresp_valid_i;
        end else begin
            mem_done = mem_wresp_valid_i;
        end
    end

    assign req_ready_o       = (state_q == UC_IDLE);
    assign capture_o         = accept;
    assign mem_rd_valid_o    = (state_q == UC_MEM_REQ) && op_rd;
    assign mem_wr_valid_o    = ((state_q == UC_MEM_REQ) && !op_rd) || (state_q == UC_MEM_W_REQ);
    assign mem_wdata_valid_o = ((state_q == UC_MEM_REQ) && !op_rd)
                               || (state_q == UC_MEM_WDATA_REQ);
    assign rsp_capture_o     = (state_q == UC_MEM_WAIT_RSP);
    assign core_rsp_valid_o  = (state_q == UC_CORE_RSP);
    assign lr_done_o         = rsp_capture_o && (req_q_i.op == OP_LR) && mem_rresp_valid_i;

    // SC always consumes the reservation, other AMOs only drop it on a hit
    assign rsrv_set_o = accept && (req_op_i == OP_LR);
    assign rsrv_clr_o = accept && ((req_op_i == OP_SC) || (is_amo_op(req_op_i) && rsrv_hit_i));
    assign sc_nores_o = accept && (req_op_i == OP_SC) && !rsrv_hit_i;

    always_comb begin
        state_d   = state_q;
        rd_seen_d = 1'b0;
        wr_seen_d = 1'b0;
        case (state_q)
            UC_IDLE: begin
                if (accept) begin
                    state_d = sc_nores_o ? UC_CORE_RSP : UC_MEM_REQ;
                end
            end
            UC_MEM_REQ: begin
                if (op_rd) begin
                    if (mem_rd_ready_i) begin
                        state_d = UC_MEM_WAIT_RSP;
                    end
                end else if (mem_wr_ready_i && mem_wdata_ready_i) begin
                    state_d = UC_MEM_WAIT_RSP;
                end else if (mem_wr_ready_i) begin
                    state_d = UC_MEM_WDATA_REQ;
                end else if (mem_wdata_ready_i) begin
                    state_d = UC_MEM_W_REQ;
                end
            end
            UC_MEM_W_REQ: begin
                if (mem_wr_ready_i) begin
                    state_d = UC_MEM_WAIT_RSP;
                end
            end
            UC_MEM_WDATA_REQ: begin
                if (mem_wdata_ready_i) begin
                    state_d = UC_MEM_WAIT_RSP;
                end
            end
            UC_MEM_WAIT_RSP: begin
                rd_seen_d = rd_done;
                wr_seen_d = wr_done;
                if (mem_done) begin
                    state_d = req_q_i.need_rsp ? UC_CORE_RSP : UC_IDLE;
                end
            end
            UC_CORE_RSP: begin
                if (core_rsp_ready_i) begin
                    state_d = UC_IDLE;
                end
            end
            default: begin
                state_d = UC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= UC_IDLE;
            rd_seen_q <= 1'b0;
            wr_seen_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_seen_q <= rd_seen_d;
            wr_seen_q <= wr_seen_d;
        end
    end

    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_rresp_valid_i || mem_wresp_valid_i) |-> (state_q == UC_MEM_WAIT_RSP))
        else $error("uc_ctrl: memory response outside of wait state");

    a_atomic_need_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((state_q != UC_IDLE) && is_atomic_op(req_q_i.op)) |-> req_q_i.need_rsp)
        else $error("uc_ctrl: atomic request without response");

    a_atomic_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((state_q != UC_IDLE) && is_atomic_op(req_q_i.op)) |-> (req_q_i.size inside {2, 3}))
        else $error("uc_ctrl: atomic request not 4 or 8 bytes");

endmodule

/* logic/uc_mem_req.sv */
// Captured core request and its encoding into memory read, write and data beats
`timescale 1ns/1ps

module uc_mem_req import uc_pkg::*; (
    input  logic       clk_i,
    input  logic       capture_i,
    input  uc_req_t    req_i,
    output uc_req_t    req_q_o,
    output mem_req_t   mem_rd_o,
    output mem_req_t   mem_wr_o,
    output mem_wdata_t mem_wdata_o
);

    uc_req_t req_q;

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            req_q <= req_i;
        end
    end

    assign req_q_o = req_q;

    // Read channel carries a plain or exclusive load
    always_comb begin
        mem_rd_o.addr = req_q.addr;
        mem_rd_o.size = req_q.size;
        mem_rd_o.cmd  = MEM_READ;
        mem_rd_o.amo  = AMO_LDEX;
        if (req_q.op == OP_LR) begin
            mem_rd_o.cmd = MEM_ATOMIC;
        end
    end

    // Plain stores leave the amo field as a don't-care
    always_comb begin
        mem_wr_o.addr = req_q.addr;
        mem_wr_o.size = req_q.size;
        mem_wr_o.cmd  = MEM_ATOMIC;
        mem_wr_o.amo  = AMO_LDEX;
        case (req_q.op)
            OP_SC:   mem_wr_o.amo = AMO_STEX;
            OP_SWAP: mem_wr_o.amo = AMO_SWAP;
            OP_ADD:  mem_wr_o.amo = AMO_ADD;
            OP_AND:  mem_wr_o.amo = AMO_CLR;
            OP_OR:   mem_wr_o.amo = AMO_SET;
            OP_XOR:  mem_wr_o.amo = AMO_EOR;
            OP_MAX:  mem_wr_o.amo = AMO_SMAX;
            OP_MAXU: mem_wr_o.amo = AMO_UMAX;
            OP_MIN:  mem_wr_o.amo = AMO_SMIN;
            OP_MINU: mem_wr_o.amo = AMO_UMIN;
            default: mem_wr_o.cmd = MEM_WRITE;
        endcase
    end

    // AND becomes a bit clear, so memory gets the complement
    assign mem_wdata_o.data = (req_q.op == OP_AND) ? ~req_q.data : req_q.data;
    assign mem_wdata_o.be   = req_q.be;

endmodule

/* logic/lrsc_rsrv.sv */
// LR/SC reservation register with request hit check and snoop invalidation
`timescale 1ns/1ps

module lrsc_rsrv import uc_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  uc_req_t           req_q_i,
    input  logic              set_i,
    input  logic              clr_i,
    input  logic              lr_done_i,
    input  mem_rresp_t        mem_rresp_i,
    input  logic              snoop_valid_i,
    input  logic [ADDR_W-1:0] snoop_addr_i,
    input  logic [SIZE_W-1:0] snoop_size_i,
    output logic              hit_o
);

    logic              valid_q;
    logic              pend_q;
    logic [ADDR_W-1:0] addr_q;
    logic              snoop_rsrv;
    logic              snoop_pend;

    // True when word of a lies in the range written at s_addr with size s_size
    function automatic logic covers(input logic [ADDR_W-1:0] a,
                                    input logic [ADDR_W-1:0] s_addr,
                                    input logic [SIZE_W-1:0] s_size);
        logic [LINE_OFFSET_W:0] words;
        logic [LINE_OFFSET_W:0] base;
        logic [LINE_OFFSET_W:0] word;
        if (s_size < SIZE_W'(3)) begin
            words = 1;
        end else begin
            words = {{LINE_OFFSET_W{1'b0}}, 1'b1} << (s_size - SIZE_W'(3));
        end
        base = {{(WORD_OFF_W+1){1'b0}}, s_addr[LINE_OFFSET_W-1:WORD_OFF_W]};
        word = {{(WORD_OFF_W+1){1'b0}}, a[LINE_OFFSET_W-1:WORD_OFF_W]};
        return (a[ADDR_W-1:LINE_OFFSET_W] == s_addr[ADDR_W-1:LINE_OFFSET_W])
               && (word >= base) && (word < base + words);
    endfunction

    // Size 0 reduces the range to the single request word
    assign hit_o = valid_q && covers(addr_q, req_addr_i, '0);

    assign snoop_rsrv = snoop_valid_i && covers(addr_q, snoop_addr_i, snoop_size_i);
    assign snoop_pend = snoop_valid_i && covers(req_q_i.addr, snoop_addr_i, snoop_size_i);

    // A snoop during the LR itself also kills the reservation it would make
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            pend_q  <= 1'b0;
        end else if (set_i) begin
            valid_q <= 1'b0;
            pend_q  <= 1'b1;
        end else if (lr_done_i) begin
            valid_q <= pend_q & ~snoop_pend & ~mem_rresp_i.error;
            pend_q  <= 1'b0;
        end else begin
            valid_q <= valid_q & ~clr_i & ~snoop_rsrv;
            pend_q  <= pend_q & ~snoop_pend;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lr_done_i) begin
            addr_q <= req_q_i.addr;
        end
    end

endmodule

/* logic/uc_rsp.sv */
// Core response registers: read data, sticky error and SC return code
`timescale 1ns/1ps

module uc_rsp import uc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  uc_req_t    req_q_i,
    input  logic       capture_i,
    input  logic       release_i,
    input  logic       sc_nores_i,
    input  logic       mem_rresp_valid_i,
    input  mem_rresp_t mem_rresp_i,
    input  logic       mem_wresp_valid_i,
    input  mem_wresp_t mem_wresp_i,
    output core_rsp_t  core_rsp_o
);

    logic [DATA_W-1:0] rdata_q;
    logic              error_q;
    logic              sc_code_q;
    logic              err_seen;

    // Errors only matter when the core will see a response
    assign err_seen = capture_i && req_q_i.need_rsp
                      && ((mem_rresp_valid_i && mem_rresp_i.error)
                          || (mem_wresp_valid_i && mem_wresp_i.error));

    always_ff @(posedge clk_i) begin
        if (capture_i && mem_rresp_valid_i) begin
            rdata_q <= mem_rresp_i.data;
        end
        if (sc_nores_i) begin
            sc_code_q <= SC_FAILURE;
        end else if (capture_i && mem_wresp_valid_i) begin
            sc_code_q <= (mem_wresp_i.is_atomic && !mem_wresp_i.error) ? SC_SUCCESS : SC_FAILURE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            error_q <= 1'b0;
        end else if (sc_nores_i || release_i) begin
            error_q <= 1'b0;
        end else if (err_seen) begin
            error_q <= 1'b1;
        end
    end

    // SC returns its code, copied into both halves for 32-bit accesses
    always_comb begin
        core_rsp_o.rdata = rdata_q;
        if (req_q_i.op == OP_SC) begin
            if (req_q_i.size == SIZE_W'(2)) begin
                core_rsp_o.rdata = {2{31'd0, sc_code_q}};
            end else begin
                core_rsp_o.rdata = {{(DATA_W-1){1'b0}}, sc_code_q};
            end
        end
    end

    assign core_rsp_o.tag   = req_q_i.tag;
    assign core_rsp_o.error = error_q;

endmodule

/* logic/uc_handler.sv */
// Uncached request handler top: FSM, request register, reservation and response blocks
`timescale 1ns/1ps

module uc_handler import uc_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    input  uc_req_t           req_i,
    input  logic              core_rsp_ready_i,
    input  logic              mem_rd_ready_i,
    input  logic              mem_wr_ready_i,
    input  logic              mem_wdata_ready_i,
    input  logic              mem_rresp_valid_i,
    input  mem_rresp_t        mem_rresp_i,
    input  logic              mem_wresp_valid_i,
    input  mem_wresp_t        mem_wresp_i,
    input  logic              snoop_valid_i,
    input  logic [ADDR_W-1:0] snoop_addr_i,
    input  logic [SIZE_W-1:0] snoop_size_i,
    output logic              req_ready_o,
    output logic              core_rsp_valid_o,
    output core_rsp_t         core_rsp_o,
    output logic              mem_rd_valid_o,
    output mem_req_t          mem_rd_o,
    output logic              mem_wr_valid_o,
    output mem_req_t          mem_wr_o,
    output logic              mem_wdata_valid_o,
    output mem_wdata_t        mem_wdata_o,
    output logic              mem_rresp_ready_o,
    output logic              mem_wresp_ready_o
);

    uc_req_t req_q;
    logic    capture, rsrv_hit, rsrv_set, rsrv_clr, lr_done;
    logic    rsp_capture, rsp_release, sc_nores, mem_busy;

    // Responses are never back-pressured
    assign mem_rresp_ready_o = 1'b1;
    assign mem_wresp_ready_o = 1'b1;
    assign rsp_release       = core_rsp_valid_o & core_rsp_ready_i;
    assign mem_busy          = mem_rd_valid_o | mem_wr_valid_o | mem_wdata_valid_o;

    uc_ctrl u_ctrl (
        .clk_i, .rst_ni, .req_valid_i,
        .req_op_i          (req_i.op),
        .req_q_i           (req_q),
        .rsrv_hit_i        (rsrv_hit),
        .mem_rd_ready_i, .mem_wr_ready_i, .mem_wdata_ready_i,
        .mem_rresp_valid_i, .mem_wresp_valid_i, .core_rsp_ready_i,
        .req_ready_o,
        .capture_o         (capture),
        .mem_rd_valid_o, .mem_wr_valid_o, .mem_wdata_valid_o,
        .rsrv_set_o        (rsrv_set),
        .rsrv_clr_o        (rsrv_clr),
        .lr_done_o         (lr_done),
        .rsp_capture_o     (rsp_capture),
        .sc_nores_o        (sc_nores),
        .core_rsp_valid_o
    );

    uc_mem_req u_mem_req (
        .clk_i,
        .capture_i         (capture),
        .req_i,
        .req_q_o           (req_q),
        .mem_rd_o, .mem_wr_o, .mem_wdata_o
    );

    lrsc_rsrv u_rsrv (
        .clk_i, .rst_ni,
        .req_addr_i        (req_i.addr),
        .req_q_i           (req_q),
        .set_i             (rsrv_set),
        .clr_i             (rsrv_clr),
        .lr_done_i         (lr_done),
        .mem_rresp_i,
        .snoop_valid_i, .snoop_addr_i, .snoop_size_i,
        .hit_o             (rsrv_hit)
    );

    uc_rsp u_rsp (
        .clk_i, .rst_ni,
        .req_q_i           (req_q),
        .capture_i         (rsp_capture),
        .release_i         (rsp_release),
        .sc_nores_i        (sc_nores),
        .mem_rresp_valid_i, .mem_rresp_i, .mem_wresp_valid_i, .mem_wresp_i,
        .core_rsp_o
    );

    // Request payload must stay put while any memory beat is still pending
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_busy |=> (!mem_busy || $stable(req_q)))
        else $error("uc_handler: captured request changed during memory request");

endmodule

/* testbench/tb_clkgen.sv */
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge so the first active edge sees a clean reset
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* testbench/tb_uc_handler.sv */
// Testbench for the uncached handler: memory model, reservation model, stimulus and checks
`timescale 1ns/1ps

module tb_uc_handler import uc_pkg::*; ();

    localparam int NUM_TXN    = 300;
    localparam int NUM_DIRECT = 30;
    localparam int PERIOD_NS  = 8;

    logic              clk_i, rst_ni;
    logic              req_valid_i, core_rsp_ready_i;
    uc_req_t           req_i;
    logic              mem_rd_ready_i, mem_wr_ready_i, mem_wdata_ready_i;
    logic              mem_rresp_valid_i, mem_wresp_valid_i;
    mem_rresp_t        mem_rresp_i;
    mem_wresp_t        mem_wresp_i;
    logic              snoop_valid_i;
    logic [ADDR_W-1:0] snoop_addr_i;
    logic [SIZE_W-1:0] snoop_size_i;
    logic              req_ready_o, core_rsp_valid_o;
    core_rsp_t         core_rsp_o;
    logic              mem_rd_valid_o, mem_wr_valid_o, mem_wdata_valid_o;
    mem_req_t          mem_rd_o, mem_wr_o;
    mem_wdata_t        mem_wdata_o;
    logic              mem_rresp_ready_o, mem_wresp_ready_o;

    int                errors;
    int                checks;
    logic [DATA_W-1:0] mem [16];
    logic              rsv_valid;
    logic [ADDR_W-1:0] rsv_addr;

    tb_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) u_clkgen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    uc_handler DUT (.*);

    task automatic check(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic mem_amo_e amo_kind(input uc_op_e op);
        case (op)
            OP_SC:   return AMO_STEX;
            OP_SWAP: return AMO_SWAP;
            OP_ADD:  return AMO_ADD;
            OP_AND:  return AMO_CLR;
            OP_OR:   return AMO_SET;
            OP_XOR:  return AMO_EOR;
            OP_MAX:  return AMO_SMAX;
            OP_MAXU: return AMO_UMAX;
            OP_MIN:  return AMO_SMIN;
            OP_MINU: return AMO_UMIN;
            default: return AMO_LDEX;
        endcase
    endfunction

    // Memory request with the amo field cleared unless the command is atomic
    function automatic logic [DATA_W-1:0] req_fields(input mem_req_t r);
        mem_req_t m;
        m = r;
        if (m.cmd != MEM_ATOMIC) m.amo = AMO_LDEX;
        return DATA_W'(m);
    endfunction

    // New memory word after an atomic of the given kind
    function automatic logic [DATA_W-1:0] amo_result(input mem_amo_e k,
                                                     input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] wd);
        case (k)
            AMO_ADD:  return old + wd;
            AMO_CLR:  return old & ~wd;
            AMO_SET:  return old | wd;
            AMO_EOR:  return old ^ wd;
            AMO_SMAX: return ($signed(old) > $signed(wd)) ? old : wd;
            AMO_UMAX: return (old > wd) ? old : wd;
            AMO_SMIN: return ($signed(old) < $signed(wd)) ? old : wd;
            AMO_UMIN: return (old < wd) ? old : wd;
            default:  return wd;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] merge_be(input logic [DATA_W-1:0] old,
                                                   input logic [DATA_W-1:0] wd,
                                                   input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    // Snoop range starts at the snoop word and spans at least one 8-byte word
    function automatic logic snoop_covers(input logic [ADDR_W-1:0] r,
                                          input logic [ADDR_W-1:0] s,
                                          input logic [SIZE_W-1:0] sz);
        int n;
        int base;
        int w;
        n = (sz < 3) ? 1 : (1 << (sz - 3));
        base = int'(s[4:3]);
        w = int'(r[4:3]);
        return (r[ADDR_W-1:5] == s[ADDR_W-1:5]) && (w >= base) && (w < base + n);
    endfunction

    task automatic snoop(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size);
        @(negedge clk_i);
        snoop_valid_i = 1'b1;
        snoop_addr_i  = addr;
        snoop_size_i  = size;
        @(negedge clk_i);
        snoop_valid_i = 1'b0;
        if (snoop_covers(rsv_addr, addr, size)) rsv_valid = 1'b0;
    endtask

    task automatic issue(input uc_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [SIZE_W-1:0] size, input logic need_rsp,
                         input logic err, input logic atomic);
        uc_req_t           req;
        mem_req_t          exp_req;
        logic              rd_ch, need_r, need_w, nores, hit, code;
        logic              got_rd, got_wr, got_wd, s1_r, s1_w, err_r, err_w;
        logic [DATA_W-1:0] old, recv, exp_data;
        int                idx, mode;
        req.op       = op;
        req.addr     = addr;
        req.size     = size;
        req.data     = {$urandom, $urandom};
        req.be       = BE_W'($urandom);
        req.tag      = TAG_W'($urandom);
        req.need_rsp = need_rsp;
        idx          = int'(addr[6:3]);
        old          = mem[idx];
        recv         = '0;
        rd_ch        = op inside {OP_LOAD, OP_LR};
        need_r       = rd_ch || !(op inside {OP_STORE, OP_SC});
        need_w       = !rd_ch;
        hit          = rsv_valid && (rsv_addr[ADDR_W-1:3] == addr[ADDR_W-1:3]);
        nores        = (op == OP_SC) && !hit;
        if (op == OP_LR) rsv_valid = !err;
        if ((op == OP_SC) || (!rd_ch && op != OP_STORE && hit)) rsv_valid = 1'b0;
        if (op == OP_LR) rsv_addr = addr;
        exp_req.addr = addr;
        exp_req.size = size;
        exp_req.cmd  = (op == OP_LOAD) ? MEM_READ : (op == OP_STORE) ? MEM_WRITE : MEM_ATOMIC;
        exp_req.amo  = amo_kind(op);

        @(negedge clk_i);
        check("req_ready", 1, DATA_W'(req_ready_o));
        req_i       = req;
        req_valid_i = 1'b1;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        got_rd = !rd_ch || nores;
        got_wr = rd_ch || nores;
        got_wd = rd_ch || nores;
        if (nores) check("sc_nores_rsp_valid", 1, DATA_W'(core_rsp_valid_o));
        else if (rd_ch) check("mem_valid_rise", 1, DATA_W'(mem_rd_valid_o));
        else check("mem_valid_rise", 1, DATA_W'(mem_wr_valid_o & mem_wdata_valid_o));

        while (!(got_rd && got_wr && got_wd)) begin
            mem_rd_ready_i    = 1'b0;
            mem_wr_ready_i    = 1'b0;
            mem_wdata_ready_i = 1'b0;
            check("wrong_channel", 0, DATA_W'(rd_ch ? (mem_wr_valid_o | mem_wdata_valid_o)
                                                    : mem_rd_valid_o));
            if (mem_rd_valid_o && !got_rd) begin
                check("mem_rd_req", req_fields(exp_req), req_fields(mem_rd_o));
                mem_rd_ready_i = 1'($urandom);
                got_rd = mem_rd_ready_i;
            end
            if (mem_wr_valid_o && !got_wr) begin
                check("mem_wr_req", req_fields(exp_req), req_fields(mem_wr_o));
                mem_wr_ready_i = 1'($urandom);
                got_wr = mem_wr_ready_i;
            end
            if (mem_wdata_valid_o && !got_wd) begin
                check("mem_wdata", (op == OP_AND) ? ~req.data : req.data, mem_wdata_o.data);
                check("mem_wdata_be", DATA_W'(req.be), DATA_W'(mem_wdata_o.be));
                recv = mem_wdata_o.data;
                mem_wdata_ready_i = 1'($urandom);
                got_wd = mem_wdata_ready_i;
            end
            @(negedge clk_i);
        end
        mem_rd_ready_i    = 1'b0;
        mem_wr_ready_i    = 1'b0;
        mem_wdata_ready_i = 1'b0;
        check("mem_valids_done", 0,
              DATA_W'({mem_rd_valid_o, mem_wr_valid_o, mem_wdata_valid_o}));

        if (!nores) begin
            // Memory side effect of the request
            if (!err && op == OP_STORE) mem[idx] = merge_be(old, recv, req.be);
            if (!err && op == OP_SC && atomic) mem[idx] = merge_be(old, recv, req.be);
            if (!err && need_r && need_w) mem[idx] = amo_result(exp_req.amo, old, recv);
            repeat ($urandom % 4) @(negedge clk_i);
            mode  = $urandom % 3;
            err_r = err && need_r && (!need_w || 1'($urandom));
            err_w = err && need_w && !err_r;
            s1_r  = need_r && (mode != 2);
            s1_w  = need_w && (mode != 1);
            check("resp_ready", 3, DATA_W'({mem_rresp_ready_o, mem_wresp_ready_o}));
            mem_rresp_i = '{data: old, error: err_r};
            mem_wresp_i = '{error: err_w, is_atomic: atomic};
            mem_rresp_valid_i = s1_r;
            mem_wresp_valid_i = s1_w;
            @(negedge clk_i);
            mem_rresp_valid_i = need_r && !s1_r;
            mem_wresp_valid_i = need_w && !s1_w;
            if (mem_rresp_valid_i || mem_wresp_valid_i) @(negedge clk_i);
            mem_rresp_valid_i = 1'b0;
            mem_wresp_valid_i = 1'b0;
        end

        if (need_rsp) begin
            check("rsp_valid", 1, DATA_W'(core_rsp_valid_o));
            while (!core_rsp_valid_o) @(negedge clk_i);
            repeat ($urandom % 3) begin
                @(negedge clk_i);
                check("rsp_held", 1, DATA_W'(core_rsp_valid_o));
            end
            code = nores ? SC_FAILURE : ((atomic && !err) ? SC_SUCCESS : SC_FAILURE);
            if (op == OP_SC && size == 3'd2) exp_data = {31'd0, code, 31'd0, code};
            else if (op == OP_SC) exp_data = DATA_W'(code);
            else exp_data = old;
            if (op != OP_STORE) begin
                check($sformatf("%s rdata", op.name()), exp_data, core_rsp_o.rdata);
            end
            check("rsp_tag", DATA_W'(req.tag), DATA_W'(core_rsp_o.tag));
            check($sformatf("%s error", op.name()), DATA_W'(err && !nores),
                  DATA_W'(core_rsp_o.error));
            core_rsp_ready_i = 1'b1;
            @(negedge clk_i);
            core_rsp_ready_i = 1'b0;
        end else begin
            check("no_rsp", 0, DATA_W'(core_rsp_valid_o));
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        uc_op_e            op;
        void'($urandom(32'h2d03));
        errors = 0;
        checks = 0;
        rsv_valid = 1'b0;
        rsv_addr  = '0;
        req_valid_i = 1'b0;
        req_i = '0;
        core_rsp_ready_i = 1'b0;
        mem_rd_ready_i = 1'b0;
        mem_wr_ready_i = 1'b0;
        mem_wdata_ready_i = 1'b0;
        mem_rresp_valid_i = 1'b0;
        mem_wresp_valid_i = 1'b0;
        mem_rresp_i = '0;
        mem_wresp_i = '0;
        snoop_valid_i = 1'b0;
        snoop_addr_i = '0;
        snoop_size_i = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = {32'(i) ^ 32'h5a3c_0f96, 32'(i) * 32'h0101_0103};
        end
        wait (rst_ni);
        @(negedge clk_i);
        check("reset_ready", 1, DATA_W'(req_ready_o));
        check("reset_valids", 0, DATA_W'({mem_rd_valid_o, mem_wr_valid_o,
                                          mem_wdata_valid_o, core_rsp_valid_o}));

        // LR/SC pairs, missing reservation, AMO hit, snoop and failed LR
        a = 32'h0000_1008;
        issue(OP_LR, a, 3'd3, 1, 0, 1);
        issue(OP_SC, a, 3'd3, 1, 0, 1);
        issue(OP_LR, a, 3'd2, 1, 0, 1);
        issue(OP_SC, a, 3'd2, 1, 0, 1);
        issue(OP_SC, a, 3'd3, 1, 0, 1);
        issue(OP_LR, a, 3'd3, 1, 0, 1);
        issue(OP_ADD, a, 3'd3, 1, 0, 1);
        issue(OP_SC, a, 3'd2, 1, 0, 1);
        issue(OP_LR, a, 3'd3, 1, 0, 1);
        snoop(32'h0000_1000, 3'd5);
        issue(OP_SC, a, 3'd3, 1, 0, 1);
        issue(OP_LR, a, 3'd3, 1, 1, 1);
        issue(OP_SC, a, 3'd3, 1, 0, 1);
        for (int k = 4; k <= 12; k++) begin
            issue(uc_op_e'(k), 32'h0000_1010, 3'd3, 1, 0, 1);
        end

        for (int i = 0; i < NUM_TXN; i++) begin
            a  = 32'h0000_1000 | (ADDR_W'($urandom % 16) << 3);
            op = uc_op_e'($urandom % 13);
            if ($urandom % 8 == 0) snoop(a, SIZE_W'($urandom));
            if (is_atomic_op(op)) begin
                issue(op, a, SIZE_W'(2 + $urandom % 2), 1, ($urandom % 8 == 0),
                      ($urandom % 4 != 0));
            end else begin
                issue(op, a, SIZE_W'($urandom % 4), 1'($urandom), ($urandom % 8 == 0),
                      1'($urandom));
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized at 200 cycles per transaction
    initial begin
        #((NUM_TXN + NUM_DIRECT) * 200 * PERIOD_NS);
        $display("Watchdog timeout: the handler stopped responding");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* flist.f */
logic/uc_pkg.sv
logic/uc_ctrl.sv
logic/uc_mem_req.sv
logic/lrsc_rsrv.sv
logic/uc_rsp.sv
logic/uc_handler.sv
testbench/tb_clkgen.sv
testbench/tb_uc_handler.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_uc_handler
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "ALL CHECKS PASSED" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
